/* design/lsu_params.svh */
//==========================================================================
// Sizing defines for the store path of the load/store unit
// Include this wherever a depth or width default is needed
//==========================================================================
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Number of store queue slots, also works at 4 or 16
`define LSU_SQ_DEPTH    8
// Number of 32-bit words in the data memory
`define LSU_DMEM_WORDS  64
`define LSU_DATA_W      32
`define LSU_ADDR_W      32

`endif

/* design/lsu_pkg.sv */
//==========================================================================
// Shared types for the store path of the load/store unit
// Modules pull these in with a wildcard import in their header
//==========================================================================
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    // Width of a reorder buffer tag
    localparam int LSU_TAG_W = 6;

    // One data word and one byte address
    typedef logic [`LSU_DATA_W-1:0] lsu_data_t;
    typedef logic [`LSU_ADDR_W-1:0] lsu_addr_t;

    // Reorder buffer tag carried by every store op
    typedef logic [LSU_TAG_W-1:0] lsu_tag_t;

    // Store size, byte, halfword or word
    typedef enum logic [1:0] {
        SB = 2'b00,
        SH = 2'b01,
        SW = 2'b10
    } lsu_func_t;

    // One enable bit per byte lane of a word
    typedef logic [`LSU_DATA_W/8-1:0] lsu_be_t;

endpackage

`default_nettype wire

/* design/lsu_store_agu.sv */
//==========================================================================
// Address stage of the store path
// Adds base and offset of an issued store and registers the whole op,
// which then goes to the store queue as an allocation strobe
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module lsu_store_agu import lsu_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,

    input  logic      i_flush,

    // Store op from the reservation station
    input  logic      i_issue_en,
    input  lsu_addr_t i_issue_base,
    input  lsu_addr_t i_issue_offset,
    input  lsu_data_t i_issue_data,
    input  lsu_func_t i_issue_func,
    input  lsu_tag_t  i_issue_tag,

    // Allocation request to the store queue
    output logic      o_alloc_en,
    output lsu_addr_t o_alloc_addr,
    output lsu_data_t o_alloc_data,
    output lsu_func_t o_alloc_func,
    output lsu_tag_t  o_alloc_tag
);

    logic      alloc_valid;
    lsu_addr_t eff_addr;

    // Effective address is a plain add, wrapping at the address width
    assign eff_addr = i_issue_base + i_issue_offset;

    // The pending op is dropped by a flush, even one issued in the same cycle
    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            alloc_valid <= 1'b0;
        end else if (i_flush) begin
            alloc_valid <= 1'b0;
        end else begin
            alloc_valid <= i_issue_en;
        end
    end

    // Payload only moves when a new op comes in
    always_ff @(posedge clk) begin
        if (i_issue_en) begin
            o_alloc_addr <= eff_addr;
            o_alloc_data <= i_issue_data;
            o_alloc_func <= i_issue_func;
            o_alloc_tag  <= i_issue_tag;
        end
    end

    assign o_alloc_en = alloc_valid;

endmodule

`default_nettype wire

/* design/lsu_sq.sv */
//==========================================================================
// Store queue of the load/store unit
// Holds issued stores until the reorder buffer retires them by tag
// A retired store leaves combinationally toward the commit stage
// One allocation and one retire may happen in the same cycle
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_sq import lsu_pkg::*; #(
    parameter int SQ_DEPTH = `LSU_SQ_DEPTH
) (
    input  logic      clk,
    input  logic      n_rst,

    input  logic      i_flush,
    output logic      o_full,

    // New store op from the address stage
    input  logic      i_alloc_en,
    input  lsu_addr_t i_alloc_addr,
    input  lsu_data_t i_alloc_data,
    input  lsu_func_t i_alloc_func,
    input  lsu_tag_t  i_alloc_tag,

    // Retire request from the reorder buffer
    input  logic      i_retire_en,
    input  lsu_tag_t  i_retire_tag,

    // Retired store toward the commit stage
    output logic      o_sq_retire_en,
    output lsu_addr_t o_sq_retire_addr,
    output lsu_data_t o_sq_retire_data,
    output lsu_func_t o_sq_retire_func
);

    localparam int SLOT_W = $clog2(SQ_DEPTH);

    // Per-slot state
    logic              slot_valid [SQ_DEPTH];
    lsu_func_t         slot_func  [SQ_DEPTH];
    lsu_addr_t         slot_addr  [SQ_DEPTH];
    lsu_data_t         slot_data  [SQ_DEPTH];
    lsu_tag_t          slot_tag   [SQ_DEPTH];

    logic [SQ_DEPTH-1:0] empty;
    logic [SQ_DEPTH-1:0] empty_dec;
    logic [SQ_DEPTH-1:0] alloc_select;
    logic [SQ_DEPTH-1:0] retire_select;
    logic                one_empty;
    logic                allocating;
    logic                retire_hit;
    logic [SLOT_W-1:0]   retire_slot;

    // A slot is empty when its valid bit is clear
    // At most one valid slot should match the retire tag
    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            empty[i]         = ~slot_valid[i];
            retire_select[i] = slot_valid[i] && (slot_tag[i] == i_retire_tag);
        end
    end

    // Lowest set bit of the empty vector picks the slot to fill
    assign empty_dec    = empty - SQ_DEPTH'(1);
    assign alloc_select = empty & ~empty_dec;
    // Exactly one bit set means only one slot is left
    assign one_empty    = (|empty) && ~|(empty & empty_dec);
    assign allocating   = i_alloc_en && (|empty);

    // Full also covers the op that may still sit in the address stage
    assign o_full = ~|empty || (one_empty && i_alloc_en);

    // Turn the one-hot retire select into a slot number
    always_comb begin
        logic [SLOT_W-1:0] r;
        r = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (retire_select[i]) begin
                r = r | SLOT_W'(i);
            end
        end
        retire_slot = r;
    end

    // A tag held by no valid slot retires nothing
    assign retire_hit       = |retire_select;
    assign o_sq_retire_en   = i_retire_en && retire_hit;
    assign o_sq_retire_addr = slot_addr[retire_slot];
    assign o_sq_retire_data = slot_data[retire_slot];
    assign o_sq_retire_func = slot_func[retire_slot];

    // Valid bits are set on allocate, cleared on retire, and all cleared by flush
    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                slot_valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                if (i_flush) begin
                    slot_valid[i] <= 1'b0;
                end else if (allocating && alloc_select[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (o_sq_retire_en && retire_select[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    // Write the payload of a newly allocated op into its slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (allocating && alloc_select[i]) begin
                slot_func[i] <= i_alloc_func;
                slot_addr[i] <= i_alloc_addr;
                slot_data[i] <= i_alloc_data;
                slot_tag[i]  <= i_alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* design/lsu_store_align.sv */
//==========================================================================
// Commit stage of the store path
// Turns a retired store into a word address, byte enables and lane-shifted
// data, registered for one cycle before the memory write
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align import lsu_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,

    // Retired store from the queue
    input  logic      i_retire_en,
    input  lsu_addr_t i_retire_addr,
    input  lsu_data_t i_retire_data,
    input  lsu_func_t i_retire_func,

    // Aligned write to the data memory
    output logic      o_commit_en,
    output lsu_addr_t o_commit_addr,
    output lsu_be_t   o_commit_be,
    output lsu_data_t o_commit_data
);

    lsu_be_t   be;
    lsu_data_t data;

    // Byte enables from size and the low address bits
    // Misaligned halfwords and words are aligned down
    always_comb begin
        case (i_retire_func)
            SB:      be = lsu_be_t'(1) << i_retire_addr[1:0];
            SH:      be = i_retire_addr[1] ? 4'b1100 : 4'b0011;
            SW:      be = 4'b1111;
            default: be = '0;
        endcase
    end

    // Each enabled lane takes its byte from the low end of the source
    // and lanes that are off carry zero
    always_comb begin
        data = '0;
        for (int l = 0; l < $bits(lsu_be_t); l++) begin
            if (be[l]) begin
                case (i_retire_func)
                    SB:      data[8*l +: 8] = i_retire_data[7:0];
                    SH:      data[8*l +: 8] = i_retire_data[8*(l%2) +: 8];
                    default: data[8*l +: 8] = i_retire_data[8*l +: 8];
                endcase
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            o_commit_en <= 1'b0;
        end else begin
            o_commit_en <= i_retire_en;
        end
    end

    // Word address is the byte address shifted down by two
    always_ff @(posedge clk) begin
        if (i_retire_en) begin
            o_commit_addr <= {2'b00, i_retire_addr[$bits(lsu_addr_t)-1:2]};
            o_commit_be   <= be;
            o_commit_data <= data;
        end
    end

endmodule

`default_nettype wire

/* design/lsu_dmem.sv */
//==========================================================================
// Small word-organized data memory behind the store path
// Byte-enabled synchronous write, combinational read, both by word address
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_dmem import lsu_pkg::*; #(
    parameter int DMEM_WORDS = `LSU_DMEM_WORDS
) (
    input  logic      clk,

    // Write port fed by the commit stage
    input  logic      i_wr_en,
    input  lsu_addr_t i_wr_addr,
    input  lsu_be_t   i_wr_be,
    input  lsu_data_t i_wr_data,

    // Read port for observing memory contents
    input  lsu_addr_t i_rd_addr,
    output lsu_data_t o_rd_data
);

    // DMEM_WORDS is a power of two, so the low bits give the index modulo the depth
    localparam int IDX_W = $clog2(DMEM_WORDS);

    lsu_data_t        mem [DMEM_WORDS];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    assign wr_idx = i_wr_addr[IDX_W-1:0];
    assign rd_idx = i_rd_addr[IDX_W-1:0];

    // Only the enabled bytes of the word change
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            for (int b = 0; b < $bits(lsu_be_t); b++) begin
                if (i_wr_be[b]) begin
                    mem[wr_idx][8*b +: 8] <= i_wr_data[8*b +: 8];
                end
            end
        end
    end

    assign o_rd_data = mem[rd_idx];

endmodule

`default_nettype wire

/* design/lsu_store_top.sv */
//==========================================================================
// Top level of the store path
// Chains the address stage, store queue, commit stage and data memory
// The commit write and a memory read port are brought out for observation
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module lsu_store_top import lsu_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,
    input  logic      i_flush,

    input  logic      i_issue_en,
    input  lsu_addr_t i_issue_base,
    input  lsu_addr_t i_issue_offset,
    input  lsu_data_t i_issue_data,
    input  lsu_func_t i_issue_func,
    input  lsu_tag_t  i_issue_tag,

    input  logic      i_retire_en,
    input  lsu_tag_t  i_retire_tag,

    input  lsu_addr_t i_rd_addr,

    output logic      o_full,
    output logic      o_commit_en,
    output lsu_addr_t o_commit_addr,
    output lsu_be_t   o_commit_be,
    output lsu_data_t o_commit_data,
    output lsu_data_t o_rd_data
);

    // Address stage to store queue
    logic      alloc_en;
    lsu_addr_t alloc_addr;
    lsu_data_t alloc_data;
    lsu_func_t alloc_func;
    lsu_tag_t  alloc_tag;

    // Store queue to commit stage
    logic      sq_retire_en;
    lsu_addr_t sq_retire_addr;
    lsu_data_t sq_retire_data;
    lsu_func_t sq_retire_func;

    lsu_store_agu u_agu (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_issue_en     (i_issue_en),
        .i_issue_base   (i_issue_base),
        .i_issue_offset (i_issue_offset),
        .i_issue_data   (i_issue_data),
        .i_issue_func   (i_issue_func),
        .i_issue_tag    (i_issue_tag),
        .o_alloc_en     (alloc_en),
        .o_alloc_addr   (alloc_addr),
        .o_alloc_data   (alloc_data),
        .o_alloc_func   (alloc_func),
        .o_alloc_tag    (alloc_tag)
    );

    lsu_sq u_sq (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .o_full           (o_full),
        .i_alloc_en       (alloc_en),
        .i_alloc_addr     (alloc_addr),
        .i_alloc_data     (alloc_data),
        .i_alloc_func     (alloc_func),
        .i_alloc_tag      (alloc_tag),
        .i_retire_en      (i_retire_en),
        .i_retire_tag     (i_retire_tag),
        .o_sq_retire_en   (sq_retire_en),
        .o_sq_retire_addr (sq_retire_addr),
        .o_sq_retire_data (sq_retire_data),
        .o_sq_retire_func (sq_retire_func)
    );

    lsu_store_align u_align (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_retire_en   (sq_retire_en),
        .i_retire_addr (sq_retire_addr),
        .i_retire_data (sq_retire_data),
        .i_retire_func (sq_retire_func),
        .o_commit_en   (o_commit_en),
        .o_commit_addr (o_commit_addr),
        .o_commit_be   (o_commit_be),
        .o_commit_data (o_commit_data)
    );

    // The commit write goes straight into memory
    lsu_dmem u_dmem (
        .clk       (clk),
        .i_wr_en   (o_commit_en),
        .i_wr_addr (o_commit_addr),
        .i_wr_be   (o_commit_be),
        .i_wr_data (o_commit_data),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data)
    );

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
//============================================================================
// Clock and reset source for the store path testbench
// Free-running clock and an active-low reset held for a set number of cycles
//============================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic n_rst
);

    // Half a period high, half low
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset is released just after a rising edge
    initial begin
        n_rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 n_rst = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_lsu_store.sv */
//============================================================================
// Testbench for the store path top level
// Replays tb/store_input.txt, one command per line, against the DUT
// Issues, retires, flushes, waits and memory reads are checked as they go
// Run from the project root so the command file path resolves
//============================================================================
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module tb_lsu_store import lsu_pkg::*; ();

    localparam string INPUT_FILE = "tb/store_input.txt";
    localparam int    CLK_PERIOD = 8;
    localparam int    RST_CYCLES = 5;
    localparam int    DRIVE_DLY  = 1;

    // One parsed line of the command file
    // Fields not used by a command stay zero
    typedef struct {
        byte       op;
        lsu_func_t func;
        lsu_tag_t  tag;
        lsu_addr_t addr;
        lsu_addr_t offset;
        lsu_data_t data;
        lsu_be_t   be;
        logic      flag;
        int        count;
    } cmd_t;

    logic      clk;
    logic      n_rst;
    logic      i_flush;
    logic      i_issue_en;
    lsu_addr_t i_issue_base;
    lsu_addr_t i_issue_offset;
    lsu_data_t i_issue_data;
    lsu_func_t i_issue_func;
    lsu_tag_t  i_issue_tag;
    logic      i_retire_en;
    lsu_tag_t  i_retire_tag;
    lsu_addr_t i_rd_addr;
    logic      o_full;
    logic      o_commit_en;
    lsu_addr_t o_commit_addr;
    lsu_be_t   o_commit_be;
    lsu_data_t o_commit_data;
    lsu_data_t o_rd_data;

    cmd_t cmds[$];
    int   n_cmds = 0;
    // Stores the queue should be holding, counted from issues, commits and flushes
    int   held = 0;

    tb_clkgen #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (RST_CYCLES)
    ) u_clkgen (
        .clk   (clk),
        .n_rst (n_rst)
    );

    lsu_store_top uut (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_issue_en     (i_issue_en),
        .i_issue_base   (i_issue_base),
        .i_issue_offset (i_issue_offset),
        .i_issue_data   (i_issue_data),
        .i_issue_func   (i_issue_func),
        .i_issue_tag    (i_issue_tag),
        .i_retire_en    (i_retire_en),
        .i_retire_tag   (i_retire_tag),
        .i_rd_addr      (i_rd_addr),
        .o_full         (o_full),
        .o_commit_en    (o_commit_en),
        .o_commit_addr  (o_commit_addr),
        .o_commit_be    (o_commit_be),
        .o_commit_data  (o_commit_data),
        .o_rd_data      (o_rd_data)
    );

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        fail_run();
    endtask

    task automatic check_data(input string name, input lsu_data_t got, input lsu_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_be(input string name, input lsu_be_t got, input lsu_be_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_addr(input string name, input lsu_addr_t got, input lsu_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    // Every command starts and ends just after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Parse the whole command file up front so the watchdog knows its length
    task automatic load_commands();
        int        fd;
        int        code;
        string     tok;
        string     fs;
        string     rest;
        cmd_t      c;
        lsu_tag_t  tag_v;
        lsu_addr_t a_v;
        lsu_addr_t b_v;
        lsu_data_t d_v;
        lsu_be_t   be_v;
        logic      flag_v;
        int        n_v;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the command file");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            // Comment lines are skipped as a whole
            if (tok.substr(0, 0) == "#") begin
                void'($fgets(rest, fd));
                continue;
            end
            c.op     = tok[0];
            c.func   = SW;
            c.tag    = '0;
            c.addr   = '0;
            c.offset = '0;
            c.data   = '0;
            c.be     = '0;
            c.flag   = 1'b0;
            c.count  = 0;
            case (c.op)
                "I": begin
                    code = $fscanf(fd, "%s %h %h %h %h", fs, tag_v, a_v, b_v, d_v);
                    if (code != 5) begin
                        abort_run("an issue line in the command file is incomplete");
                    end
                    if (fs == "SB") begin
                        c.func = SB;
                    end else if (fs == "SH") begin
                        c.func = SH;
                    end else if (fs == "SW") begin
                        c.func = SW;
                    end else begin
                        abort_run({"unknown store size in the command file: ", fs});
                    end
                    c.tag    = tag_v;
                    c.addr   = a_v;
                    c.offset = b_v;
                    c.data   = d_v;
                end
                "R": begin
                    code = $fscanf(fd, "%h %h %h %h %h", tag_v, flag_v, a_v, be_v, d_v);
                    if (code != 5) begin
                        abort_run("a retire line in the command file is incomplete");
                    end
                    c.tag  = tag_v;
                    c.flag = flag_v;
                    c.addr = a_v;
                    c.be   = be_v;
                    c.data = d_v;
                end
                "F": begin
                end
                "W": begin
                    code = $fscanf(fd, "%d %h", n_v, flag_v);
                    if (code != 2) begin
                        abort_run("a wait line in the command file is incomplete");
                    end
                    c.count = n_v;
                    c.flag  = flag_v;
                end
                "M": begin
                    code = $fscanf(fd, "%h %h", a_v, d_v);
                    if (code != 2) begin
                        abort_run("a memory read line in the command file is incomplete");
                    end
                    c.addr = a_v;
                    c.data = d_v;
                end
                default: begin
                    abort_run({"unknown command in the command file: ", tok});
                end
            endcase
            cmds.push_back(c);
        end
        $fclose(fd);
    endtask

    // The issuer holds off while the queue reports full
    // While the op sits in the address stage the last free slot already counts as taken
    task automatic issue_store(input cmd_t c);
        int idle;
        idle = int'($urandom_range(3, 0));
        repeat (idle) next_cycle();
        while (o_full) begin
            next_cycle();
        end
        i_issue_en     = 1'b1;
        i_issue_func   = c.func;
        i_issue_tag    = c.tag;
        i_issue_base   = c.addr;
        i_issue_offset = c.offset;
        i_issue_data   = c.data;
        next_cycle();
        i_issue_en = 1'b0;
        check_bit("o_full", o_full, held >= `LSU_SQ_DEPTH - 1);
        // Second cycle lets the op land in its queue slot
        next_cycle();
        held++;
    endtask

    // Commit shows one cycle after the retire strobe
    task automatic retire_store(input cmd_t c);
        i_retire_en  = 1'b1;
        i_retire_tag = c.tag;
        next_cycle();
        i_retire_en = 1'b0;
        check_bit("o_commit_en", o_commit_en, c.flag);
        if (c.flag) begin
            check_addr("o_commit_addr", o_commit_addr, c.addr);
            check_be("o_commit_be", o_commit_be, c.be);
            check_data("o_commit_data", o_commit_data, c.data);
            held--;
        end
    endtask

    task automatic flush_queue();
        i_flush = 1'b1;
        next_cycle();
        i_flush = 1'b0;
        held    = 0;
    endtask

    task automatic wait_and_check_full(input cmd_t c);
        repeat (c.count) next_cycle();
        check_bit("o_full", o_full, c.flag);
    endtask

    // One cycle also covers a write from a commit shown just before
    task automatic read_word(input cmd_t c);
        i_rd_addr = c.addr;
        next_cycle();
        check_data("o_rd_data", o_rd_data, c.data);
    endtask

    initial begin
        i_flush        = 1'b0;
        i_issue_en     = 1'b0;
        i_issue_base   = '0;
        i_issue_offset = '0;
        i_issue_data   = '0;
        i_issue_func   = SB;
        i_issue_tag    = '0;
        i_retire_en    = 1'b0;
        i_retire_tag   = '0;
        i_rd_addr      = '0;
        void'($urandom(65));
        load_commands();
        if (cmds.size() == 0) begin
            abort_run("the command file holds no commands");
        end
        n_cmds = cmds.size();
        wait (n_rst === 1'b1);
        next_cycle();
        foreach (cmds[i]) begin
            case (cmds[i].op)
                "I":     issue_store(cmds[i]);
                "R":     retire_store(cmds[i]);
                "F":     flush_queue();
                "W":     wait_and_check_full(cmds[i]);
                default: read_word(cmds[i]);
            endcase
        end
        $display("All tests passed");
        $finish;
    end

    // Budget of 20 cycles per command, 100 spare, plus the reset cycles
    initial begin
        wait (n_cmds > 0);
        repeat (20 * n_cmds + 100 + RST_CYCLES) @(posedge clk);
        abort_run("timeout, the commands did not finish within the cycle budget");
    end

endmodule

`default_nettype wire

/* tb/store_input.txt */
# I size tag base offset data | R tag valid word_addr be data | F
# W cycles full | M word_addr data   (numbers in hex, W cycles in decimal)
# Word store then retire then read back
I SW 01 00000080 00000010 deadbeef
R 01 1 00000024 f deadbeef
M 00000024 deadbeef
# Bytes into every lane of one word, merged in memory
I SB 02 00000040 00000000 000000a1
I SB 03 00000040 00000001 000000b2
I SB 04 00000040 00000003 ffffffc3
I SB 05 0000003e 00000004 000000d4
R 02 1 00000010 1 000000a1
R 03 1 00000010 2 0000b200
R 04 1 00000010 8 c3000000
R 05 1 00000010 4 00d40000
M 00000010 c3d4b2a1
# Halfwords, aligned and misaligned, and a misaligned word
I SH 06 00000050 00000002 1234abcd
I SH 07 00000050 00000000 5678ef01
R 06 1 00000014 c abcd0000
R 07 1 00000014 3 0000ef01
M 00000014 abcdef01
I SH 08 00000050 00000001 00002222
I SH 09 00000050 00000003 00003333
I SW 0a 00000050 00000007 cafef00d
R 08 1 00000014 3 00002222
R 09 1 00000014 c 33330000
R 0a 1 00000015 f cafef00d
M 00000014 33332222
M 00000015 cafef00d
# Retire out of issue order
I SW 10 00000000 00000000 11111111
I SW 11 00000000 00000004 22222222
I SW 12 00000008 00000000 33333333
R 12 1 00000002 f 33333333
R 10 1 00000000 f 11111111
R 11 1 00000001 f 22222222
M 00000000 11111111
M 00000001 22222222
M 00000002 33333333
# Tags held by no slot
R 3f 0 00000000 0 00000000
R 10 0 00000000 0 00000000
# Fill the queue
I SW 20 000000a0 00000000 c0de0020
I SW 21 000000a0 00000004 c0de0021
I SW 22 000000a0 00000008 c0de0022
I SW 23 000000a0 0000000c c0de0023
I SW 24 000000a0 00000010 c0de0024
I SW 25 000000a0 00000014 c0de0025
I SW 26 000000a0 00000018 c0de0026
W 0 0
I SW 27 000000a0 0000001c c0de0027
W 0 1
R 23 1 0000002b f c0de0023
W 2 0
I SW 28 000000c0 00000000 c0de0028
W 0 1
R 20 1 00000028 f c0de0020
R 21 1 00000029 f c0de0021
R 22 1 0000002a f c0de0022
R 24 1 0000002c f c0de0024
R 25 1 0000002d f c0de0025
R 26 1 0000002e f c0de0026
R 27 1 0000002f f c0de0027
R 28 1 00000030 f c0de0028
M 0000002b c0de0023
M 0000002f c0de0027
M 00000030 c0de0028
# Flush discards held stores
I SW 30 000000e0 00000000 11223344
I SW 31 000000e0 00000004 55667788
R 30 1 00000038 f 11223344
R 31 1 00000039 f 55667788
I SW 32 000000e0 00000000 deadd00d
I SB 33 000000e4 00000001 000000ee
I SH 34 000000e0 00000002 0000beef
F
W 0 0
R 32 0 00000000 0 00000000
R 33 0 00000000 0 00000000
R 34 0 00000000 0 00000000
M 00000038 11223344
M 00000039 55667788
I SW 35 000000e8 00000000 99aabbcc
R 35 1 0000003a f 99aabbcc
M 0000003a 99aabbcc

/* files.f */
+incdir+design
design/lsu_pkg.sv
design/lsu_store_agu.sv
design/lsu_sq.sv
design/lsu_store_align.sv
design/lsu_dmem.sv
design/lsu_store_top.sv
tb/tb_clkgen.sv
tb/tb_lsu_store.sv

/* Makefile */
# Verilator build and run of the store path testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_store
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

# A failing run ends in $$fatal, which makes the binary exit nonzero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
